//--- eci_defs.svh
// --------------------------------------------------
// CDMA adjustment stage parameters
// Queue depth and field widths shared by the
// package, the adjuster and the engines
// --------------------------------------------------

`ifndef ECI_DEFS_SVH
`define ECI_DEFS_SVH

// Entries per queue, request and ctl alike
`define ECI_N_OUTSTANDING 8

// Request fields
`define ECI_ADDR_W 32
`define ECI_LEN_W 16

// Stream data, one keep bit per byte
`define ECI_DATA_W 64
`define ECI_KEEP_W (`ECI_DATA_W / 8)

`endif

//--- eci_pkg.sv
// --------------------------------------------------
// CDMA adjustment stage types
// Request word, stream beat and engine states
// --------------------------------------------------

`include "eci_defs.svh"

package eci_pkg;

  // Plain vectors with a meaning
  typedef logic [`ECI_ADDR_W-1:0] eci_addr_t;
  typedef logic [`ECI_LEN_W-1:0]  eci_len_t;
  typedef logic [`ECI_DATA_W-1:0] eci_data_t;
  typedef logic [`ECI_KEEP_W-1:0] eci_keep_t;

  // Request word, same for read and write
  // len counts beats
  typedef struct packed {
    eci_addr_t addr;
    eci_len_t  len;
    logic      ctl;
  } dma_req_t;

  // One stream beat
  typedef struct packed {
    eci_data_t tdata;
    eci_keep_t tkeep;
    logic      tlast;
  } axis_beat_t;

  // Serial engine states
  typedef enum logic [1:0] {
    ENG_IDLE = 2'd0,
    ENG_XFER = 2'd1,
    ENG_DONE = 2'd2
  } eng_state_t;

endpackage

//--- req_queue.sv
// --------------------------------------------------
// First-word-fall-through FIFO
// Circular buffer of QDEPTH elements of QTYPE with
// valid/ready on both sides; head shows one cycle
// after a push into an empty queue
// --------------------------------------------------

`timescale 1ns/10ps

module req_queue #(
  parameter type QTYPE  = logic,
  parameter int  QDEPTH = 8
) (
  input  logic aclk,
  input  logic rst,

  // Sink side
  input  logic val_snk,
  output logic rdy_snk,
  input  QTYPE data_snk,

  // Source side
  output logic val_src,
  input  logic rdy_src,
  output QTYPE data_src
);

  localparam int PTR_W = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CNT_W = $clog2(QDEPTH + 1);

  QTYPE mem [QDEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Accept while not full, present while not empty
  assign rdy_snk  = (count != CNT_W'(QDEPTH));
  assign val_src  = (count != '0);
  assign data_src = mem[rd_ptr];

  assign push = val_snk & rdy_snk;
  assign pop  = val_src & rdy_src;

  // Storage
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= data_snk;
    end
  end

  // Pointers wrap at QDEPTH, which need not be a power of two
  always_ff @(posedge aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QDEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QDEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keep the count
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- eci_chan.sv
// --------------------------------------------------
// One direction of the CDMA adjuster
// Queues requests toward the engine, records each
// issued ctl bit in order and forwards an engine
// done only for requests that had ctl set; data
// passes through untouched
// --------------------------------------------------

`timescale 1ns/10ps

`include "eci_defs.svh"

module eci_chan (
  input  logic                aclk,
  input  logic                rst,

  // Requester side
  input  eci_pkg::dma_req_t   s_req,
  input  logic                s_req_valid,
  output logic                s_req_ready,
  output logic                s_done,

  // Engine side
  output eci_pkg::dma_req_t   m_req,
  output logic                m_req_valid,
  input  logic                m_req_ready,
  input  logic                m_done,

  // Data stream
  input  eci_pkg::axis_beat_t s_beat,
  input  logic                s_beat_valid,
  output logic                s_beat_ready,
  output eci_pkg::axis_beat_t m_beat,
  output logic                m_beat_valid,
  input  logic                m_beat_ready
);

  import eci_pkg::*;

  dma_req_t que_req;
  logic     que_valid;
  logic     issue;
  logic     seq_ready;
  logic     seq_valid;
  logic     seq_ctl;

  // Incoming requests
  req_queue #(
    .QTYPE  (dma_req_t),
    .QDEPTH (`ECI_N_OUTSTANDING)
  ) u_req_q (
    .aclk     (aclk),
    .rst      (rst),
    .val_snk  (s_req_valid),
    .rdy_snk  (s_req_ready),
    .data_snk (s_req),
    .val_src  (que_valid),
    .rdy_src  (issue),
    .data_src (que_req)
  );

  // ctl bits of issued requests, popped by engine done
  req_queue #(
    .QTYPE  (logic),
    .QDEPTH (`ECI_N_OUTSTANDING)
  ) u_seq_q (
    .aclk     (aclk),
    .rst      (rst),
    .val_snk  (issue),
    .rdy_snk  (seq_ready),
    .data_snk (que_req.ctl),
    .val_src  (seq_valid),
    .rdy_src  (m_done),
    .data_src (seq_ctl)
  );

  // Issue needs a waiting request, a free engine and room to record ctl
  assign issue       = que_valid & m_req_ready & seq_ready;
  assign m_req_valid = issue;
  assign m_req       = que_req;

  // Completion masked by the recorded ctl bit
  assign s_done = m_done & seq_valid & seq_ctl;

  // Data pass-through
  assign m_beat       = s_beat;
  assign m_beat_valid = s_beat_valid;
  assign s_beat_ready = m_beat_ready;

endmodule

//--- eci_adj.sv
// --------------------------------------------------
// CDMA adjuster
// Read and write channels, each queuing requests
// and gating completions by their ctl bit
// --------------------------------------------------

`timescale 1ns/10ps

module eci_adj (
  input  logic                aclk,
  input  logic                rst,

  // Read channel
  input  eci_pkg::dma_req_t   rd_s_req,
  input  logic                rd_s_req_valid,
  output logic                rd_s_req_ready,
  output logic                rd_s_done,
  output eci_pkg::dma_req_t   rd_m_req,
  output logic                rd_m_req_valid,
  input  logic                rd_m_req_ready,
  input  logic                rd_m_done,
  input  eci_pkg::axis_beat_t rd_s_beat,
  input  logic                rd_s_beat_valid,
  output logic                rd_s_beat_ready,
  output eci_pkg::axis_beat_t rd_m_beat,
  output logic                rd_m_beat_valid,
  input  logic                rd_m_beat_ready,

  // Write channel
  input  eci_pkg::dma_req_t   wr_s_req,
  input  logic                wr_s_req_valid,
  output logic                wr_s_req_ready,
  output logic                wr_s_done,
  output eci_pkg::dma_req_t   wr_m_req,
  output logic                wr_m_req_valid,
  input  logic                wr_m_req_ready,
  input  logic                wr_m_done,
  input  eci_pkg::axis_beat_t wr_s_beat,
  input  logic                wr_s_beat_valid,
  output logic                wr_s_beat_ready,
  output eci_pkg::axis_beat_t wr_m_beat,
  output logic                wr_m_beat_valid,
  input  logic                wr_m_beat_ready
);

  // Read direction, data comes from the engine
  eci_chan u_rd (
    .aclk         (aclk),
    .rst          (rst),
    .s_req        (rd_s_req),
    .s_req_valid  (rd_s_req_valid),
    .s_req_ready  (rd_s_req_ready),
    .s_done       (rd_s_done),
    .m_req        (rd_m_req),
    .m_req_valid  (rd_m_req_valid),
    .m_req_ready  (rd_m_req_ready),
    .m_done       (rd_m_done),
    .s_beat       (rd_s_beat),
    .s_beat_valid (rd_s_beat_valid),
    .s_beat_ready (rd_s_beat_ready),
    .m_beat       (rd_m_beat),
    .m_beat_valid (rd_m_beat_valid),
    .m_beat_ready (rd_m_beat_ready)
  );

  // Write direction, data goes to the engine
  eci_chan u_wr (
    .aclk         (aclk),
    .rst          (rst),
    .s_req        (wr_s_req),
    .s_req_valid  (wr_s_req_valid),
    .s_req_ready  (wr_s_req_ready),
    .s_done       (wr_s_done),
    .m_req        (wr_m_req),
    .m_req_valid  (wr_m_req_valid),
    .m_req_ready  (wr_m_req_ready),
    .m_done       (wr_m_done),
    .s_beat       (wr_s_beat),
    .s_beat_valid (wr_s_beat_valid),
    .s_beat_ready (wr_s_beat_ready),
    .m_beat       (wr_m_beat),
    .m_beat_valid (wr_m_beat_valid),
    .m_beat_ready (wr_m_beat_ready)
  );

endmodule

//--- cdma_rd_engine.sv
// --------------------------------------------------
// Serial CDMA read engine
// Takes one request at a time and emits len beats
// of addr plus beat index, then pulses done
// --------------------------------------------------

`timescale 1ns/10ps

module cdma_rd_engine (
  input  logic                aclk,
  input  logic                rst,
  input  eci_pkg::dma_req_t   req,
  input  logic                req_valid,
  output logic                req_ready,
  output eci_pkg::axis_beat_t beat,
  output logic                beat_valid,
  input  logic                beat_ready,
  output logic                done
);

  import eci_pkg::*;

  eng_state_t state;
  eci_len_t   cnt;
  eci_len_t   last_q;
  eci_addr_t  addr_q;
  logic       is_last;

  assign req_ready = (state == ENG_IDLE);
  assign done      = (state == ENG_DONE);
  assign is_last   = (cnt == last_q);

  // Beat built from registers, so it holds under back-pressure
  assign beat_valid = (state == ENG_XFER);
  assign beat.tdata = eci_data_t'(addr_q) + eci_data_t'(cnt);
  assign beat.tkeep = '1;
  assign beat.tlast = is_last;

  // Latch request fields, zero length runs as one beat
  always_ff @(posedge aclk) begin
    if (req_valid && req_ready) begin
      addr_q <= req.addr;
      last_q <= (req.len == '0) ? '0 : req.len - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state <= ENG_IDLE;
      cnt   <= '0;
    end else begin
      unique case (state)
        ENG_IDLE: begin
          cnt <= '0;
          if (req_valid) begin
            state <= ENG_XFER;
          end
        end
        ENG_XFER: begin
          if (beat_ready) begin
            if (is_last) begin
              state <= ENG_DONE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        // One-cycle done strobe
        default: state <= ENG_IDLE;
      endcase
    end
  end

endmodule

//--- cdma_wr_engine.sv
// --------------------------------------------------
// Serial CDMA write engine
// Takes one request at a time, sinks len beats and
// pulses done; the beat count alone ends a transfer
// --------------------------------------------------

`timescale 1ns/10ps

module cdma_wr_engine (
  input  logic                aclk,
  input  logic                rst,
  input  eci_pkg::dma_req_t   req,
  input  logic                req_valid,
  output logic                req_ready,
  input  eci_pkg::axis_beat_t beat,
  input  logic                beat_valid,
  output logic                beat_ready,
  output logic                done
);

  import eci_pkg::*;

  eng_state_t state;
  eci_len_t   cnt;
  eci_len_t   last_q;

  assign req_ready  = (state == ENG_IDLE);
  assign beat_ready = (state == ENG_XFER);
  assign done       = (state == ENG_DONE);

  // Index of final beat, zero length counts as one
  always_ff @(posedge aclk) begin
    if (req_valid && req_ready) begin
      last_q <= (req.len == '0) ? '0 : req.len - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      state <= ENG_IDLE;
      cnt   <= '0;
    end else begin
      unique case (state)
        ENG_IDLE: begin
          cnt <= '0;
          if (req_valid) begin
            state <= ENG_XFER;
          end
        end
        ENG_XFER: begin
          // Incoming tlast plays no part here
          if (beat_valid) begin
            if (cnt == last_q) begin
              state <= ENG_DONE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

endmodule

//--- eci_top.sv
// --------------------------------------------------
// CDMA adjustment stage top level
// Adjuster with a serial read and write engine
// behind it, requests and streams at the ports
// --------------------------------------------------

`timescale 1ns/10ps

module eci_top (
  input  logic                aclk,
  input  logic                rst,

  // Read
  input  eci_pkg::dma_req_t   rd_req,
  input  logic                rd_req_valid,
  output logic                rd_req_ready,
  output logic                rd_done,
  output eci_pkg::axis_beat_t rd_beat,
  output logic                rd_beat_valid,
  input  logic                rd_beat_ready,

  // Write
  input  eci_pkg::dma_req_t   wr_req,
  input  logic                wr_req_valid,
  output logic                wr_req_ready,
  output logic                wr_done,
  input  eci_pkg::axis_beat_t wr_beat,
  input  logic                wr_beat_valid,
  output logic                wr_beat_ready
);

  import eci_pkg::*;

  // Adjuster to read engine
  dma_req_t   rd_eng_req;
  logic       rd_eng_req_valid;
  logic       rd_eng_req_ready;
  logic       rd_eng_done;
  axis_beat_t rd_eng_beat;
  logic       rd_eng_beat_valid;
  logic       rd_eng_beat_ready;

  // Adjuster to write engine
  dma_req_t   wr_eng_req;
  logic       wr_eng_req_valid;
  logic       wr_eng_req_ready;
  logic       wr_eng_done;
  axis_beat_t wr_eng_beat;
  logic       wr_eng_beat_valid;
  logic       wr_eng_beat_ready;

  eci_adj u_adj (
    .aclk (aclk), .rst (rst),
    .rd_s_req (rd_req), .rd_s_req_valid (rd_req_valid), .rd_s_req_ready (rd_req_ready),
    .rd_s_done (rd_done),
    .rd_m_req (rd_eng_req), .rd_m_req_valid (rd_eng_req_valid),
    .rd_m_req_ready (rd_eng_req_ready), .rd_m_done (rd_eng_done),
    .rd_s_beat (rd_eng_beat), .rd_s_beat_valid (rd_eng_beat_valid),
    .rd_s_beat_ready (rd_eng_beat_ready),
    .rd_m_beat (rd_beat), .rd_m_beat_valid (rd_beat_valid), .rd_m_beat_ready (rd_beat_ready),
    .wr_s_req (wr_req), .wr_s_req_valid (wr_req_valid), .wr_s_req_ready (wr_req_ready),
    .wr_s_done (wr_done),
    .wr_m_req (wr_eng_req), .wr_m_req_valid (wr_eng_req_valid),
    .wr_m_req_ready (wr_eng_req_ready), .wr_m_done (wr_eng_done),
    .wr_s_beat (wr_beat), .wr_s_beat_valid (wr_beat_valid), .wr_s_beat_ready (wr_beat_ready),
    .wr_m_beat (wr_eng_beat), .wr_m_beat_valid (wr_eng_beat_valid),
    .wr_m_beat_ready (wr_eng_beat_ready)
  );

  // Read engine sources the read stream
  cdma_rd_engine u_rd_eng (
    .aclk (aclk), .rst (rst),
    .req (rd_eng_req), .req_valid (rd_eng_req_valid), .req_ready (rd_eng_req_ready),
    .beat (rd_eng_beat), .beat_valid (rd_eng_beat_valid), .beat_ready (rd_eng_beat_ready),
    .done (rd_eng_done)
  );

  // Write engine sinks the write stream
  cdma_wr_engine u_wr_eng (
    .aclk (aclk), .rst (rst),
    .req (wr_eng_req), .req_valid (wr_eng_req_valid), .req_ready (wr_eng_req_ready),
    .beat (wr_eng_beat), .beat_valid (wr_eng_beat_valid), .beat_ready (wr_eng_beat_ready),
    .done (wr_eng_done)
  );

endmodule

//--- tb_eci_top.sv
// --------------------------------------------------
// Testbench for the CDMA adjustment stage top level
// Random read and write requests, a reference for
// the read beat pattern, done strobe tracking and
// queue-full checks
// --------------------------------------------------

`timescale 1ns/10ps

`include "eci_defs.svh"

module tb_eci_top;

  import eci_pkg::*;

  localparam int          TMO  = 5000;
  localparam logic [31:0] SEED = 32'ha114_1f3e;

  logic       aclk;
  logic       rst;
  dma_req_t   rd_req;
  logic       rd_req_valid;
  logic       rd_req_ready;
  logic       rd_done;
  axis_beat_t rd_beat;
  logic       rd_beat_valid;
  logic       rd_beat_ready;
  dma_req_t   wr_req;
  logic       wr_req_valid;
  logic       wr_req_ready;
  logic       wr_done;
  axis_beat_t wr_beat;
  logic       wr_beat_valid;
  logic       wr_beat_ready;

  // Scoreboard filled on request handshakes
  dma_req_t   rd_exp_q[$];
  dma_req_t   wr_exp_q[$];
  int         wr_len_q[$];
  int         rd_idx;
  int         wr_idx;
  logic       rd_done_due;
  logic       wr_done_due;
  int         rd_done_cnt;
  int         wr_done_cnt;
  logic       rd_held;
  axis_beat_t rd_held_beat;
  logic       saw_rd_full;
  logic       saw_wr_full;

  // Stimulus knobs and bookkeeping
  int          stall_pct;
  int          gap_pct;
  logic [31:0] main_rng;
  logic [31:0] drv_rng;
  int          drv_beat_idx;
  logic        wr_acc;
  int          errors;
  int          err_mark;
  int          tests_run;
  int          tests_failed;
  string       test_name;
  logic        hung;

  eci_top dut (
    .aclk (aclk), .rst (rst),
    .rd_req (rd_req), .rd_req_valid (rd_req_valid), .rd_req_ready (rd_req_ready),
    .rd_done (rd_done),
    .rd_beat (rd_beat), .rd_beat_valid (rd_beat_valid), .rd_beat_ready (rd_beat_ready),
    .wr_req (wr_req), .wr_req_valid (wr_req_valid), .wr_req_ready (wr_req_ready),
    .wr_done (wr_done),
    .wr_beat (wr_beat), .wr_beat_valid (wr_beat_valid), .wr_beat_ready (wr_beat_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int rand_below(input int n);
    main_rng = lcg_next(main_rng);
    return int'(main_rng[31:16]) % n;
  endfunction

  function automatic dma_req_t make_req(input int max_len);
    dma_req_t r;
    main_rng = lcg_next(main_rng);
    r.addr = main_rng;
    r.len  = eci_len_t'(rand_below(max_len + 1));
    r.ctl  = (rand_below(2) == 1);
    return r;
  endfunction

  // Zero length runs as a single beat
  function automatic int eff_len(input dma_req_t r);
    return (r.len == '0) ? 1 : int'(r.len);
  endfunction

  // Expected read beat k is addr plus k with tlast on len-1
  function automatic axis_beat_t ref_beat(input dma_req_t r, input int idx);
    axis_beat_t b;
    b.tdata = eci_data_t'(r.addr) + eci_data_t'(idx);
    b.tkeep = '1;
    b.tlast = (idx == eff_len(r) - 1);
    return b;
  endfunction

  task automatic check_beat(input axis_beat_t got, input axis_beat_t exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %h/%h/%b, expected %h/%h/%b", $time, msg,
               got.tdata, got.tkeep, got.tlast, exp.tdata, exp.tkeep, exp.tlast);
    end
  endtask

  task automatic check_done(input int got, input int exp, input string msg);
    if (got != exp) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, msg, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    hung = 1'b1;
    $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, TMO);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      $display("test %-10s ok", test_name);
    end else begin
      tests_failed++;
      $display("test %-10s FAILED, %0d errors", test_name, errors - err_mark);
    end
  endtask

  // Hold valid until ready is seen at a rising edge
  task automatic send_rd(input dma_req_t r);
    int waited;
    waited       = 0;
    rd_req       = r;
    rd_req_valid = 1'b1;
    do begin
      @(posedge aclk);
      waited++;
    end while (!rd_req_ready && waited < TMO && !hung);
    if (!rd_req_ready && !hung) begin
      report_timeout("rd_req acceptance");
    end
    #1;
    rd_req_valid = 1'b0;
  endtask

  task automatic send_wr(input dma_req_t r);
    int waited;
    waited       = 0;
    wr_req       = r;
    wr_req_valid = 1'b1;
    do begin
      @(posedge aclk);
      waited++;
    end while (!wr_req_ready && waited < TMO && !hung);
    if (!wr_req_ready && !hung) begin
      report_timeout("wr_req acceptance");
    end
    #1;
    wr_req_valid = 1'b0;
    // Beat driver now owes this many beats
    wr_len_q.push_back(eff_len(r));
  endtask

  task automatic run_reads(input int n, input int max_len, input int gap, output int n_ctl);
    dma_req_t r;
    int       i;
    n_ctl = 0;
    for (i = 0; i < n; i++) begin
      r = make_req(max_len);
      if (r.ctl) n_ctl++;
      send_rd(r);
      repeat (rand_below(gap + 1)) begin
        @(posedge aclk);
        #1;
      end
    end
  endtask

  task automatic run_writes(input int n, input int max_len, input int gap, output int n_ctl);
    dma_req_t r;
    int       i;
    n_ctl = 0;
    for (i = 0; i < n; i++) begin
      r = make_req(max_len);
      if (r.ctl) n_ctl++;
      send_wr(r);
      repeat (rand_below(gap + 1)) begin
        @(posedge aclk);
        #1;
      end
    end
  endtask

  // Everything issued has drained and its done slot has passed
  task automatic wait_idle();
    int   waited;
    logic busy;
    waited = 0;
    do begin
      @(posedge aclk);
      #1;
      waited++;
      busy = (rd_exp_q.size() != 0) || (wr_exp_q.size() != 0) || (wr_len_q.size() != 0) ||
             rd_done_due || wr_done_due;
    end while (busy && waited < TMO && !hung);
    if (busy && !hung) begin
      report_timeout("drain of outstanding requests");
    end
  endtask

  // Beat driver for random rd_beat_ready and gapped write beats
  initial begin
    drv_rng       = ~SEED;
    drv_beat_idx  = 0;
    rd_beat_ready = 1'b1;
    wr_beat       = '0;
    wr_beat_valid = 1'b0;
    forever begin
      @(posedge aclk);
      wr_acc = wr_beat_valid && wr_beat_ready;
      #1;
      drv_rng       = lcg_next(drv_rng);
      rd_beat_ready = (int'(drv_rng[31:24]) % 100) >= stall_pct;
      if (wr_acc) begin
        drv_beat_idx++;
        if (drv_beat_idx == wr_len_q[0]) begin
          void'(wr_len_q.pop_front());
          drv_beat_idx = 0;
        end
      end
      drv_rng = lcg_next(drv_rng);
      // A beat not yet taken stays as it is
      if (!(wr_beat_valid && !wr_acc)) begin
        if (wr_len_q.size() != 0 && (int'(drv_rng[31:24]) % 100) >= gap_pct) begin
          wr_beat_valid = 1'b1;
          wr_beat.tdata = {drv_rng, ~drv_rng};
          wr_beat.tkeep = '1;
          wr_beat.tlast = (drv_beat_idx == wr_len_q[0] - 1);
        end else begin
          wr_beat_valid = 1'b0;
        end
      end
    end
  end

  // Monitor sampling at the rising edge
  always @(posedge aclk) begin
    if (rst) begin
      rd_exp_q.delete();
      wr_exp_q.delete();
      rd_idx      = 0;
      wr_idx      = 0;
      rd_done_due = 1'b0;
      wr_done_due = 1'b0;
      rd_held     = 1'b0;
    end else begin
      // Done strobe due one cycle after the last beat and only with ctl
      check_flag(rd_done, rd_done_due, "rd_done strobe");
      check_flag(wr_done, wr_done_due, "wr_done strobe");
      if (rd_done) rd_done_cnt++;
      if (wr_done) wr_done_cnt++;
      rd_done_due = 1'b0;
      wr_done_due = 1'b0;
      if (!rd_req_ready) saw_rd_full = 1'b1;
      if (!wr_req_ready) saw_wr_full = 1'b1;

      if (rd_req_valid && rd_req_ready) rd_exp_q.push_back(rd_req);
      if (wr_req_valid && wr_req_ready) wr_exp_q.push_back(wr_req);

      // Stalled read beat must not move
      if (rd_held) begin
        check_flag(rd_beat_valid, 1'b1, "rd_beat_valid dropped while stalled");
        check_beat(rd_beat, rd_held_beat, "rd_beat changed while stalled");
      end
      rd_held      = rd_beat_valid && !rd_beat_ready;
      rd_held_beat = rd_beat;

      if (rd_beat_valid && rd_beat_ready) begin
        if (rd_exp_q.size() == 0) begin
          errors++;
          $display("Read beat at %0t with no outstanding read request", $time);
        end else begin
          check_beat(rd_beat, ref_beat(rd_exp_q[0], rd_idx), "read beat");
          rd_idx++;
          if (rd_idx == eff_len(rd_exp_q[0])) begin
            rd_done_due = rd_exp_q[0].ctl;
            void'(rd_exp_q.pop_front());
            rd_idx = 0;
          end
        end
      end

      if (wr_beat_valid && wr_beat_ready) begin
        if (wr_exp_q.size() == 0) begin
          errors++;
          $display("Write beat taken at %0t with no outstanding write request", $time);
        end else begin
          wr_idx++;
          if (wr_idx == eff_len(wr_exp_q[0])) begin
            wr_done_due = wr_exp_q[0].ctl;
            void'(wr_exp_q.pop_front());
            wr_idx = 0;
          end
        end
      end
    end
  end

  initial begin : main_seq
    int n_rd;
    int n_wr;
    int rd_base;
    int wr_base;
    main_rng     = SEED;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    hung         = 1'b0;
    stall_pct    = 0;
    gap_pct      = 0;
    rd_done_cnt  = 0;
    wr_done_cnt  = 0;
    saw_rd_full  = 1'b0;
    saw_wr_full  = 1'b0;
    rst          = 1'b1;
    rd_req       = '0;
    rd_req_valid = 1'b0;
    wr_req       = '0;
    wr_req_valid = 1'b0;
    repeat (3) @(posedge aclk);
    #1;
    rst = 1'b0;

    begin_test("reset");
    @(posedge aclk);
    check_flag(rd_beat_valid, 1'b0, "rd_beat_valid after reset");
    check_flag(rd_done, 1'b0, "rd_done after reset");
    check_flag(wr_done, 1'b0, "wr_done after reset");
    check_flag(rd_req_ready, 1'b1, "rd_req_ready after reset");
    check_flag(wr_req_ready, 1'b1, "wr_req_ready after reset");
    check_flag(wr_beat_ready, 1'b0, "wr_beat_ready after reset");
    #1;
    end_test();

    begin_test("read");
    rd_base = rd_done_cnt;
    run_reads(8, 12, 2, n_rd);
    wait_idle();
    check_done(rd_done_cnt - rd_base, n_rd, "read done count");
    end_test();

    // Both directions at once with random ctl
    begin_test("ctl_mask");
    rd_base = rd_done_cnt;
    wr_base = wr_done_cnt;
    gap_pct = 20;
    fork
      run_reads(10, 4, 1, n_rd);
      run_writes(10, 4, 1, n_wr);
    join
    wait_idle();
    check_done(rd_done_cnt - rd_base, n_rd, "read done count");
    check_done(wr_done_cnt - wr_base, n_wr, "write done count");
    gap_pct = 0;
    end_test();

    begin_test("read_stall");
    rd_base   = rd_done_cnt;
    stall_pct = 50;
    run_reads(8, 10, 0, n_rd);
    wait_idle();
    check_done(rd_done_cnt - rd_base, n_rd, "read done count");
    stall_pct = 0;
    end_test();

    begin_test("write_gaps");
    wr_base = wr_done_cnt;
    gap_pct = 50;
    run_writes(8, 10, 1, n_wr);
    wait_idle();
    check_done(wr_done_cnt - wr_base, n_wr, "write done count");
    gap_pct = 0;
    end_test();

    // Slow data side so the request queues fill up
    begin_test("overflow");
    rd_base     = rd_done_cnt;
    wr_base     = wr_done_cnt;
    stall_pct   = 70;
    gap_pct     = 70;
    saw_rd_full = 1'b0;
    saw_wr_full = 1'b0;
    run_reads(`ECI_N_OUTSTANDING + 6, 6, 0, n_rd);
    run_writes(`ECI_N_OUTSTANDING + 6, 6, 0, n_wr);
    wait_idle();
    check_flag(saw_rd_full, 1'b1, "rd_req_ready low at some point");
    check_flag(saw_wr_full, 1'b1, "wr_req_ready low at some point");
    check_done(rd_done_cnt - rd_base, n_rd, "read done count");
    check_done(wr_done_cnt - wr_base, n_wr, "write done count");
    stall_pct = 0;
    gap_pct   = 0;
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
eci_pkg.sv
req_queue.sv
eci_chan.sv
eci_adj.sv
cdma_rd_engine.sv
cdma_wr_engine.sv
eci_top.sv
tb_eci_top.sv

//--- Bender.yml
package:
  name: eci_adj

dependencies: {}

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - eci_pkg.sv
      - req_queue.sv
      - eci_chan.sv
      - eci_adj.sv
      - cdma_rd_engine.sv
      - cdma_wr_engine.sv
      - eci_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_eci_top.sv
